// File: project.f
verilog/spi_timing_pkg.sv
verilog/spi_cmd_pkg.sv
verilog/spi_cmd_decode.sv
verilog/spi_sck_gen.sv
verilog/spi_shift_engine.sv
verilog/spi_result_capture.sv
verilog/spi_peripheral_top.sv
bench/spi_checker.sv
bench/spi_bench.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module spi_bench \
	-f project.f -Mdir obj_dir -o spi_sim &&
./obj_dir/spi_sim | tee sim.log ||
{ echo "build or simulation did not complete"; exit 1; }

grep -q "Verification failed" sim.log && { echo "simulation reported errors"; exit 1; }
echo "simulation clean"
exit 0

// File: bench/spi_bench.sv
`timescale 1ns/1ps

module spi_bench;
	import spi_timing_pkg::*;
	import spi_cmd_pkg::*;

	localparam int SCK_DIV = SCK_DIV_DEFAULT;
	localparam int NUM_CS  = NUM_CS_DEFAULT;
	localparam int N_CMDS  = 40;
	// Longest command plus gap, then slack for reset
	localparam int CMD_CYCLES   = 2 * FRAME_WIDTH * SCK_DIV + 20;
	localparam int LIMIT_CYCLES = N_CMDS * CMD_CYCLES + 200;

	logic              CLK50MHZ;
	logic              RST;
	logic              cmd_valid;
	spi_op_t           cmd_op;
	logic [3:0]        cmd_chan;
	logic [15:0]       cmd_data;
	logic              busy;
	logic              cmd_error;
	logic              rsp_valid;
	logic [15:0]       rsp_data;
	logic              spi_sck;
	logic [NUM_CS-1:0] spi_cs;
	logic              spi_mosi;
	// Quiet line until the first select
	logic              spi_miso = 1'b0;

	// Slave model
	logic [FRAME_WIDTH-1:0] reply_word;
	logic [FRAME_WIDTH-1:0] tx_shift;
	logic [FRAME_WIDTH-1:0] rx_frame;
	logic                   sck_q = 1'b0;
	logic                   sel_q = 1'b0;

	logic [31:0] lcg_state = 32'hedda86be;
	int          tests;
	int          errors;
	int          dropped;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// About one in eight opcodes invalid
	function automatic spi_op_t pick_op(input logic [31:0] r);
		logic [3:0] raw;
		if (r[2:0] == 3'd0) begin
			raw = r[11:8];
			// Top bit set turns any valid code invalid
			if (raw == 4'd1 || raw == 4'd3 || raw == 4'd6)
				raw = raw ^ 4'h8;
			return spi_op_t'(raw);
		end
		case (r[5:4])
			2'd0:    return OP_READ_ADC;
			2'd1:    return OP_WRITE_DAC;
			default: return OP_SET_GAIN;
		endcase
	endfunction

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	spi_peripheral_top #(.SCK_DIV(SCK_DIV), .NUM_CS(NUM_CS)) UUT (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_chan(cmd_chan), .cmd_data(cmd_data),
		.busy(busy), .cmd_error(cmd_error), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
		.spi_sck(spi_sck), .spi_cs(spi_cs), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

	spi_checker #(.NUM_CS(NUM_CS)) u_checker (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_chan(cmd_chan), .cmd_data(cmd_data),
		.busy(busy), .cmd_error(cmd_error), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
		.spi_sck(spi_sck), .spi_cs(spi_cs), .spi_mosi(spi_mosi),
		.rx_frame(rx_frame), .reply_word(reply_word),
		.tests(tests), .errors(errors), .dropped(dropped)
	);

	//////////////////////////////////////////////////
	// SPI slave, mode 0, acts on falling CLK50MHZ
	//////////////////////////////////////////////////
	always @(negedge CLK50MHZ) begin
		if (!(&spi_cs)) begin
			if (!sel_q) begin
				// Just selected, fresh reply word
				reply_word = lcg_next();
				tx_shift   = reply_word;
				rx_frame   = '0;
			end else if (sck_q && !spi_sck) begin
				tx_shift = {tx_shift[FRAME_WIDTH-2:0], 1'b0};
			end
			if (!sck_q && spi_sck)
				rx_frame = {rx_frame[FRAME_WIDTH-2:0], spi_mosi};
			spi_miso = tx_shift[FRAME_WIDTH-1];
		end
		sck_q = spi_sck;
		sel_q = !(&spi_cs);
	end

	// One-cycle host strobe from a falling edge
	task automatic send_command(input spi_op_t op, input logic [3:0] chan,
			input logic [15:0] data);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_chan  = chan;
		cmd_data  = data;
		@(negedge CLK50MHZ);
		cmd_valid = 1'b0;
	endtask

	// Second strobe somewhere in a running transfer
	task automatic strobe_while_busy(input logic [3:0] delay, input logic [31:0] d);
		while (!busy)
			@(negedge CLK50MHZ);
		repeat (delay) @(negedge CLK50MHZ);
		send_command(pick_op(d), d[31:28], d[23:8]);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] s;
		spi_op_t     op;
		RST       = 1'b1;
		cmd_valid = 1'b0;
		cmd_op    = OP_READ_ADC;
		cmd_chan  = '0;
		cmd_data  = '0;
		repeat (2) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RST = 1'b0;
		repeat (2) @(negedge CLK50MHZ);
		for (int i = 0; i < N_CMDS; i++) begin
			r  = lcg_next();
			d  = lcg_next();
			// Drawn here while the bus is idle
			s  = lcg_next();
			op = pick_op(r);
			send_command(op, r[15:12], d[15:0]);
			if (op == OP_READ_ADC || op == OP_WRITE_DAC || op == OP_SET_GAIN) begin
				if (r[24])
					strobe_while_busy(r[19:16], s);
				while (!rsp_valid)
					@(negedge CLK50MHZ);
			end
			repeat (3 + r[27:26]) @(negedge CLK50MHZ);
		end
		repeat (4) @(negedge CLK50MHZ);
		if (tests != N_CMDS + 1)
			$display("Only %0d of %0d tests were checked", tests, N_CMDS + 1);
		$display("%0d tests, %0d errors, %0d busy strobes dropped", tests, errors, dropped);
		if (errors == 0 && tests == N_CMDS + 1)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (LIMIT_CYCLES) @(posedge CLK50MHZ);
		$display("Timeout after %0d cycles, a transfer never completed", LIMIT_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: bench/spi_checker.sv
`timescale 1ns/1ps

module spi_checker #(
	parameter int NUM_CS = spi_cmd_pkg::NUM_CS_DEFAULT
) (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	// Host side of the DUT
	input  logic                 cmd_valid,
	input  spi_cmd_pkg::spi_op_t cmd_op,
	input  logic [3:0]           cmd_chan,
	input  logic [15:0]          cmd_data,
	input  logic                 busy,
	input  logic                 cmd_error,
	input  logic                 rsp_valid,
	input  logic [15:0]          rsp_data,
	// SPI bus and what the slave model saw
	input  logic                 spi_sck,
	input  logic [NUM_CS-1:0]    spi_cs,
	input  logic                 spi_mosi,
	input  logic [31:0]          rx_frame,
	input  logic [31:0]          reply_word,
	output int                   tests,
	output int                   errors,
	output int                   dropped
);
	import spi_cmd_pkg::*;

	localparam logic [NUM_CS-1:0] CS_IDLE = '1;

	int                test_cnt = 0;
	int                err_cnt = 0;
	int                drop_cnt = 0;
	int                test_errs;
	int                sck_rises;
	int                cs_falls;
	logic              in_flight;
	logic              err_expect;
	logic              reset_seen;
	logic              cs_wrong;
	logic              sck_q;
	logic              cs_idle_q;
	spi_op_t           cur_op;
	logic [31:0]       exp_frame;
	logic [NUM_CS-1:0] exp_cs;
	string             name;

	assign tests   = test_cnt;
	assign errors  = err_cnt;
	assign dropped = drop_cnt;

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error %s %s expected %h actual %h", name, what, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s: %s", name, msg);
		err_cnt++;
	endtask

	// One line per finished test
	task automatic close_test();
		test_cnt++;
		if (err_cnt == test_errs)
			$display("%s ok", name);
		else
			$display("%s done with %0d error(s)", name, err_cnt - test_errs);
	endtask

	always @(posedge CLK50MHZ) begin
		if (RST) begin
			in_flight  = 1'b0;
			err_expect = 1'b0;
			reset_seen = 1'b0;
			sck_q      = 1'b0;
			cs_idle_q  = 1'b1;
		end else begin
			// Quiet bus right after reset
			if (!reset_seen) begin
				name      = "reset_idle";
				test_errs = err_cnt;
				check_value("spi_cs", 32'(CS_IDLE), 32'(spi_cs));
				check_value("sck_mosi_busy_rsp_err", 32'd0,
					32'({spi_sck, spi_mosi, busy, rsp_valid, cmd_error}));
				close_test();
				reset_seen = 1'b1;
			end
			// cmd_error only one cycle after a rejected opcode
			if (cmd_error !== err_expect)
				report_problem(err_expect ? "no cmd_error strobe for an invalid opcode"
					: "cmd_error strobe without an invalid opcode");
			if (err_expect)
				close_test();
			err_expect = 1'b0;
			if (!in_flight && spi_cs !== CS_IDLE)
				report_problem("chip select low with no transfer running");
			if (!in_flight && rsp_valid)
				report_problem("rsp_valid with no transfer running");

			//////////////////////////////////////////////////
			// Command intake, model of the busy rule
			//////////////////////////////////////////////////
			if (cmd_valid && in_flight) begin
				drop_cnt++;
			end else if (cmd_valid) begin
				name      = $sformatf("cmd%0d_op%0d", test_cnt, cmd_op);
				test_errs = err_cnt;
				if (cmd_op == OP_READ_ADC || cmd_op == OP_WRITE_DAC || cmd_op == OP_SET_GAIN) begin
					in_flight = 1'b1;
					cur_op    = cmd_op;
					// Opcode, channel, data, zero pad
					exp_frame = {cmd_op, cmd_chan, cmd_data, 8'h00};
					exp_cs    = CS_IDLE;
					exp_cs[(cmd_op == OP_WRITE_DAC) ? CS_DAC : CS_ADC] = 1'b0;
					sck_rises = 0;
					cs_falls  = 0;
					cs_wrong  = 1'b0;
				end else begin
					err_expect = 1'b1;
				end
			end

			// Bus activity of the running transfer
			if (in_flight && spi_cs !== CS_IDLE) begin
				if (spi_cs !== exp_cs)
					cs_wrong = 1'b1;
				if (cs_idle_q)
					cs_falls++;
				if (spi_sck && !sck_q)
					sck_rises++;
			end
			if (in_flight && rsp_valid) begin
				check_value("frame", exp_frame, rx_frame);
				// ADC read gives the low half, writes give the status half
				check_value("rsp_data", (cur_op == OP_READ_ADC) ? 32'(reply_word[15:0])
					: 32'(reply_word[31:16]), 32'(rsp_data));
				check_value("sck_cycles", 32'd32, 32'(sck_rises));
				check_value("busy", 32'd1, 32'(busy));
				if (cs_wrong || cs_falls != 1)
					report_problem("chip select was not the opcode's device alone for one frame");
				close_test();
				in_flight = 1'b0;
			end
			sck_q     = spi_sck;
			cs_idle_q = (spi_cs === CS_IDLE);
		end
	end

endmodule

// File: verilog/spi_peripheral_top.sv
`timescale 1ns/1ps

module spi_peripheral_top #(
	parameter int SCK_DIV = spi_timing_pkg::SCK_DIV_DEFAULT,
	parameter int NUM_CS  = spi_cmd_pkg::NUM_CS_DEFAULT
) (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	// Host command
	input  logic                 cmd_valid,
	input  spi_cmd_pkg::spi_op_t cmd_op,
	input  logic [3:0]           cmd_chan,
	input  logic [15:0]          cmd_data,
	output logic                 busy,
	output logic                 cmd_error,
	// Host response
	output logic                 rsp_valid,
	output logic [15:0]          rsp_data,
	// SPI bus
	output logic                 spi_sck,
	output logic [NUM_CS-1:0]    spi_cs,
	output logic                 spi_mosi,
	input  logic                 spi_miso
);
	import spi_timing_pkg::*;
	import spi_cmd_pkg::*;

	// Decode to engine
	logic                   start;
	logic [FRAME_WIDTH-1:0] frame;
	logic [NUM_CS-1:0]      cs_sel;
	spi_op_t                op_latched;
	// Clock generator handshake
	logic                   run;
	logic                   sck_level;
	logic                   sck_rise;
	logic                   sck_fall;
	// Engine to result
	logic                   done;
	logic [FRAME_WIDTH-1:0] rx_word;

	//////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////
	spi_cmd_decode #(.NUM_CS(NUM_CS)) u_decode (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_chan(cmd_chan), .cmd_data(cmd_data),
		.busy(busy), .start(start), .frame(frame), .cs_sel(cs_sel),
		.op_latched(op_latched), .cmd_error(cmd_error)
	);

	spi_sck_gen #(.SCK_DIV(SCK_DIV)) u_sck_gen (
		.CLK50MHZ(CLK50MHZ), .RST(RST), .run(run),
		.sck_level(sck_level), .sck_rise(sck_rise), .sck_fall(sck_fall)
	);

	spi_shift_engine #(.NUM_CS(NUM_CS)) u_engine (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.start(start), .frame(frame), .cs_sel(cs_sel),
		.sck_level(sck_level), .sck_rise(sck_rise), .sck_fall(sck_fall),
		.spi_miso(spi_miso), .run(run), .spi_sck(spi_sck), .spi_cs(spi_cs),
		.spi_mosi(spi_mosi), .busy(busy), .done(done), .rx_word(rx_word)
	);

	spi_result_capture u_result (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.done(done), .rx_word(rx_word), .op_latched(op_latched),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data)
	);

endmodule

// File: verilog/spi_result_capture.sv
`timescale 1ns/1ps

module spi_result_capture (
	input  logic                                   CLK50MHZ,
	input  logic                                   RST,
	// From the shift engine
	input  logic                                   done,
	input  logic [spi_timing_pkg::FRAME_WIDTH-1:0] rx_word,
	// Opcode of the transfer in flight
	input  spi_cmd_pkg::spi_op_t                   op_latched,
	// Response to host
	output logic                                   rsp_valid,
	output logic [15:0]                            rsp_data
);
	import spi_cmd_pkg::*;

	logic [15:0] field;

	//////////////////////////////////////////////////
	// Reply field select
	//////////////////////////////////////////////////

	// Sample for ADC read, status word otherwise
	assign field = reply_field(op_latched, rx_word);

	// Strobe one cycle after done
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= done;
	end

	// Data held until next transfer
	always_ff @(posedge CLK50MHZ) begin
		if (done)
			rsp_data <= field;
	end

endmodule

// File: verilog/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine #(
	parameter int NUM_CS = spi_cmd_pkg::NUM_CS_DEFAULT
) (
	input  logic                                   CLK50MHZ,
	input  logic                                   RST,
	input  logic                                   start,
	input  logic [spi_timing_pkg::FRAME_WIDTH-1:0] frame,
	input  logic [NUM_CS-1:0]                      cs_sel,
	// Clock enables from the SCK generator
	input  logic                                   sck_level,
	input  logic                                   sck_rise,
	input  logic                                   sck_fall,
	input  logic                                   spi_miso,
	output logic                                   run,
	// SPI lines
	output logic                                   spi_sck,
	output logic [NUM_CS-1:0]                      spi_cs,
	output logic                                   spi_mosi,
	output logic                                   busy,
	output logic                                   done,
	output logic [spi_timing_pkg::FRAME_WIDTH-1:0] rx_word
);
	import spi_timing_pkg::*;

	localparam logic [BIT_CNT_W-1:0] BIT_CNT_FULL = BIT_CNT_W'(FRAME_WIDTH);

	typedef enum logic [1:0] {
		ST_TRIG_WAITING,
		ST_SENDING,
		ST_DONE
	} state_t;

	state_t                 state;
	logic [FRAME_WIDTH-1:0] shreg;
	logic [BIT_CNT_W-1:0]   bit_cnt;
	logic [NUM_CS-1:0]      cs_sel_q;
	logic                   cs_low;
	logic                   last_bit;

	// Some device selected
	assign cs_low   = ~&spi_cs;
	assign last_bit = (bit_cnt == BIT_CNT_FULL);

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= ST_TRIG_WAITING;
		end else begin
			case (state)
				ST_TRIG_WAITING:
					if (start)
						state <= ST_SENDING;
				ST_SENDING:
					// Deselect edge ends the frame
					if (sck_fall && cs_low && last_bit)
						state <= ST_DONE;
				// Two cycles, second one covers the response strobe
				ST_DONE:
					if (!done)
						state <= ST_TRIG_WAITING;
				default:
					state <= ST_TRIG_WAITING;
			endcase
		end
	end

	// Shift register, MSB out and MISO in at bit 0
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_TRIG_WAITING && start) begin
			shreg    <= frame;
			cs_sel_q <= cs_sel;
		end else if (state == ST_SENDING && sck_rise && cs_low) begin
			shreg <= {shreg[FRAME_WIDTH-2:0], spi_miso};
		end
	end

	// Count sampled bits
	always_ff @(posedge CLK50MHZ) begin
		if (RST || state == ST_TRIG_WAITING)
			bit_cnt <= '0;
		else if (state == ST_SENDING && sck_rise && cs_low)
			bit_cnt <= bit_cnt + 1'b1;
	end

	//////////////////////////////////////////////////
	// Chip select, MOSI and done
	//////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_cs   <= '1;
			spi_mosi <= 1'b0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state == ST_SENDING && sck_fall) begin
				if (!cs_low) begin
					// First falling edge selects the device
					spi_cs   <= ~cs_sel_q;
					spi_mosi <= shreg[FRAME_WIDTH-1];
				end else if (last_bit) begin
					spi_cs   <= '1;
					spi_mosi <= 1'b0;
					done     <= 1'b1;
				end else begin
					spi_mosi <= shreg[FRAME_WIDTH-1];
				end
			end
		end
	end

	// SCK only reaches the bus while selected
	assign spi_sck = cs_low ? sck_level : 1'b0;
	assign run     = (state == ST_SENDING);
	assign busy    = (state != ST_TRIG_WAITING);
	assign rx_word = shreg;

	a_one_cs_low: assert property (@(posedge CLK50MHZ) disable iff (RST)
		$onehot0(~spi_cs));

	// Frame ends on a full bit count and a released bus
	a_done_full: assert property (@(posedge CLK50MHZ) disable iff (RST)
		done |-> last_bit && !cs_low && $past(sck_fall));

	// No sample beyond the frame length
	a_no_extra_rise: assert property (@(posedge CLK50MHZ) disable iff (RST)
		(sck_rise && cs_low) |-> bit_cnt < BIT_CNT_FULL);

endmodule

// File: verilog/spi_sck_gen.sv
`timescale 1ns/1ps

module spi_sck_gen #(
	parameter int SCK_DIV = spi_timing_pkg::SCK_DIV_DEFAULT
) (
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic run,
	output logic sck_level,
	output logic sck_rise,
	output logic sck_fall
);
	// Wide enough for SCK_DIV of 1 as well
	localparam int CNT_W = $clog2(SCK_DIV + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCK_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic             half_done;

	// End of one half period
	assign half_done = (div_cnt == CNT_LAST);

	//////////////////////////////////////////////////
	// Divider and edge enables
	//////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !run) begin
			// Idle, restart in low phase
			div_cnt   <= '0;
			sck_level <= 1'b0;
			sck_rise  <= 1'b0;
			sck_fall  <= 1'b0;
		end else begin
			sck_rise <= 1'b0;
			sck_fall <= 1'b0;
			if (half_done) begin
				div_cnt   <= '0;
				sck_level <= ~sck_level;
				// Pulse lines up with the new level
				sck_rise  <= ~sck_level;
				sck_fall  <= sck_level;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// File: verilog/spi_cmd_decode.sv
`timescale 1ns/1ps

module spi_cmd_decode #(
	parameter int NUM_CS = spi_cmd_pkg::NUM_CS_DEFAULT
) (
	input  logic                                   CLK50MHZ,
	input  logic                                   RST,
	// Host command strobe
	input  logic                                   cmd_valid,
	input  spi_cmd_pkg::spi_op_t                   cmd_op,
	input  logic [3:0]                             cmd_chan,
	input  logic [15:0]                            cmd_data,
	input  logic                                   busy,
	// Towards the shift engine
	output logic                                   start,
	output logic [spi_timing_pkg::FRAME_WIDTH-1:0] frame,
	output logic [NUM_CS-1:0]                      cs_sel,
	// Towards result stage
	output spi_cmd_pkg::spi_op_t                   op_latched,
	output logic                                   cmd_error
);
	import spi_timing_pkg::*;
	import spi_cmd_pkg::*;

	logic                   accept;
	logic                   op_ok;
	logic [FRAME_WIDTH-1:0] frame_next;

	// Engine raises busy one cycle late, so block the start cycle too
	assign accept = cmd_valid && !busy && !start;
	assign op_ok  = op_is_valid(cmd_op);

	//////////////////////////////////////////////////
	// Frame packing
	//////////////////////////////////////////////////
	always_comb begin
		frame_next = '0;
		frame_next[OP_MSB:OP_LSB]     = cmd_op;
		frame_next[CHAN_MSB:CHAN_LSB] = cmd_chan;
		frame_next[DATA_MSB:DATA_LSB] = cmd_data;
	end

	// Strobes, one cycle after the command
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			start     <= 1'b0;
			cmd_error <= 1'b0;
		end else begin
			start     <= accept && op_ok;
			cmd_error <= accept && !op_ok;
		end
	end

	// Payload for the engine and result stage
	always_ff @(posedge CLK50MHZ) begin
		if (accept && op_ok) begin
			frame      <= frame_next;
			cs_sel     <= '0;
			// One-hot device select
			cs_sel[op_device(cmd_op)] <= 1'b1;
			op_latched <= cmd_op;
		end
	end

	// No transfer may be launched over a running one
	a_start_not_busy: assert property (@(posedge CLK50MHZ) disable iff (RST)
		start |-> !busy);

endmodule

// File: verilog/spi_cmd_pkg.sv
package spi_cmd_pkg;

	// Host opcodes, all other codes rejected
	typedef enum logic [3:0] {
		OP_READ_ADC  = 4'd1,
		OP_WRITE_DAC = 4'd3,
		OP_SET_GAIN  = 4'd6
	} spi_op_t;

	// Chip-select indices
	localparam int CS_DAC = 0;
	localparam int CS_ADC = 1;
	localparam int NUM_CS_DEFAULT = 2;

	//////////////////////////////////////////////////
	// Frame fields, bits 7..0 stay zero
	//////////////////////////////////////////////////
	localparam int OP_MSB   = 31;
	localparam int OP_LSB   = 28;
	localparam int CHAN_MSB = 27;
	localparam int CHAN_LSB = 24;
	localparam int DATA_MSB = 23;
	localparam int DATA_LSB = 8;

	// Reply fields inside the received word
	localparam int ADC_MSB    = 15;
	localparam int ADC_LSB    = 0;
	localparam int STATUS_MSB = 31;
	localparam int STATUS_LSB = 16;

	function automatic logic op_is_valid(input spi_op_t op);
		return (op == OP_READ_ADC) || (op == OP_WRITE_DAC) || (op == OP_SET_GAIN);
	endfunction

	// Which device an opcode talks to
	function automatic int op_device(input spi_op_t op);
		return (op == OP_WRITE_DAC) ? CS_DAC : CS_ADC;
	endfunction

	// ADC read returns sample, writes return status word
	function automatic logic [15:0] reply_field(input spi_op_t op,
			input logic [STATUS_MSB:0] rx);
		if (op == OP_READ_ADC)
			return rx[ADC_MSB:ADC_LSB];
		return rx[STATUS_MSB:STATUS_LSB];
	endfunction

endpackage

// File: verilog/spi_timing_pkg.sv
package spi_timing_pkg;

	//////////////////////////////////////////////////
	// Frame geometry
	//////////////////////////////////////////////////

	// Bits in one SPI frame, opcode down to padding
	localparam int FRAME_WIDTH = 32;

	// Bit counter must reach FRAME_WIDTH itself
	localparam int BIT_CNT_W = $clog2(FRAME_WIDTH + 1);

	//////////////////////////////////////////////////
	// Serial clock
	//////////////////////////////////////////////////

	// CLK50MHZ cycles per SCK half period
	// 2 gives 12.5 MHz on the wire
	localparam int SCK_DIV_DEFAULT = 2;

endpackage
